//--- logic/decode_params.svh
// widths, field positions and CSR addresses shared by the decode RTL and its testbench
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define XLEN       64
`define REG_ADDR_W 5
`define CSR_ADDR_W 12

// one-hot ALU operation positions
`define ALU_OPS  12
`define ALU_ADD  0
`define ALU_SUB  1
`define ALU_SLT  2
`define ALU_SLTU 3
`define ALU_XOR  4
`define ALU_OR   5
`define ALU_AND  6
`define ALU_SLL  7
`define ALU_SRL  8
`define ALU_SRA  9
`define ALU_ANDN 10
`define ALU_WRI  11

// branch and jump kinds
`define BJ_OPS  8
`define BJ_BEQ  0
`define BJ_BNE  1
`define BJ_BLT  2
`define BJ_BGE  3
`define BJ_BLTU 4
`define BJ_BGEU 5
`define BJ_JALR 6
`define BJ_JAL  7

// load sizes, in funct3 order
`define LOAD_OPS 7
`define LOAD_LB  0
`define LOAD_LH  1
`define LOAD_LW  2
`define LOAD_LD  3
`define LOAD_LBU 4
`define LOAD_LHU 5
`define LOAD_LWU 6

// store sizes
`define SAVE_OPS 4
`define SAVE_SB  0
`define SAVE_SH  1
`define SAVE_SW  2
`define SAVE_SD  3

// machine CSRs held by the CSR file
`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

`endif

//--- logic/decode_pkg.sv
// vector types for the decode stage, imported by the RTL modules and the testbench
`default_nettype none

`include "decode_params.svh"

package decode_pkg;

  // data word and raw instruction
  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [31:0]      inst_t;

  // register and CSR indices
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

  // one-hot operation kinds, bit positions in the params header
  typedef logic [`ALU_OPS-1:0]  alu_info_t;
  typedef logic [`BJ_OPS-1:0]   bj_info_t;
  typedef logic [`LOAD_OPS-1:0] load_info_t;
  typedef logic [`SAVE_OPS-1:0] save_info_t;

  // writeback source
  // bit 0 execute result, bit 1 memory data, bit 2 CSR value
  typedef logic [2:0] wb_sel_t;

endpackage

`default_nettype wire

//--- logic/reg_file.sv
// integer register file with two same-cycle read ports and one write port, x0 reads as zero
`default_nettype none

module reg_file
  import decode_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire reg_addr_t rd_addr1,
  input  wire reg_addr_t rd_addr2,
  output xlen_t          rd_data1,
  output xlen_t          rd_data2,
  input  wire            wr_ena,
  input  wire reg_addr_t wr_addr,
  input  wire xlen_t     wr_data
);

  xlen_t regs [2**$bits(reg_addr_t)];

  // entry zero only ever sees the reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < $size(regs); i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // no bypass, a write shows up on the next cycle
  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

  // x0 stays zero on both ports whatever was written
  x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
    ((rd_addr1 == '0) |-> (rd_data1 == '0)) and
    ((rd_addr2 == '0) |-> (rd_data2 == '0)));

endmodule

`default_nettype wire

//--- logic/csr_file.sv
// machine CSR file with mstatus, mtvec, mepc, mcause and mscratch, one read and one write port
`default_nettype none

`include "decode_params.svh"

module csr_file
  import decode_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire csr_addr_t rd_addr,
  output xlen_t          rd_data,
  input  wire            wr_ena,
  input  wire csr_addr_t wr_addr,
  input  wire xlen_t     wr_data
);

  xlen_t mstatus;
  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mcause;
  xlen_t mscratch;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= '0;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else if (wr_ena) begin
      case (wr_addr)
        `CSR_MSTATUS:  mstatus  <= wr_data;
        // trap vector and return pc are word aligned
        `CSR_MTVEC:    mtvec    <= {wr_data[`XLEN-1:2], 2'b00};
        `CSR_MEPC:     mepc     <= {wr_data[`XLEN-1:2], 2'b00};
        `CSR_MCAUSE:   mcause   <= wr_data;
        `CSR_MSCRATCH: mscratch <= wr_data;
        default: ;
      endcase
    end
  end

  // unimplemented addresses read zero
  always_comb begin
    case (rd_addr)
      `CSR_MSTATUS:  rd_data = mstatus;
      `CSR_MTVEC:    rd_data = mtvec;
      `CSR_MEPC:     rd_data = mepc;
      `CSR_MCAUSE:   rd_data = mcause;
      `CSR_MSCRATCH: rd_data = mscratch;
      default:       rd_data = '0;
    endcase
  end

  mepc_aligned: assert property (@(posedge clk) disable iff (rst) mepc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- logic/id_stage.sv
// decode stage, splits the offered instruction, reads operands and registers the execute bundle
`default_nettype none

`include "decode_params.svh"

module id_stage
  import decode_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  // pipeline control
  input  wire            ex_allowin,
  output logic           id_allowin,
  input  wire            if_id_valid,
  output logic           id_ex_valid,
  input  wire            stall,
  // offered instruction
  input  wire xlen_t     pc_in,
  input  wire inst_t     inst_in,
  // operand reads
  output reg_addr_t      rs1_addr,
  output reg_addr_t      rs2_addr,
  output csr_addr_t      csr_rd_addr,
  input  wire xlen_t     r_data1,
  input  wire xlen_t     r_data2,
  input  wire xlen_t     csr_data,
  // registered bundle
  output xlen_t          pc_out,
  output inst_t          inst_out,
  output reg_addr_t      rs1_addr_out,
  output reg_addr_t      rs2_addr_out,
  output xlen_t          ex_op1,
  output xlen_t          ex_op2,
  output xlen_t          jmp_imm,
  output xlen_t          rs2_data,
  output logic           is_word_opt,
  output alu_info_t      alu_info,
  output bj_info_t       bj_info,
  output load_info_t     load_info,
  output save_info_t     save_info,
  output logic           mem_rd_ena,
  output logic           mem_wr_ena,
  output wb_sel_t        reg_wr_ctrl,
  output logic           rd_ena,
  output reg_addr_t      rd_addr,
  output logic           csr_wr_ena,
  output csr_addr_t      csr_wr_addr
);

  logic id_valid;
  logic accept;

  assign id_allowin  = !id_valid || (!stall && ex_allowin);
  assign id_ex_valid = id_valid && !stall;
  assign accept      = if_id_valid && id_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= if_id_valid;
    end
  end

  // instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic [6:0] funct7;
  reg_addr_t  rd;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j, zimm;

  assign opcode = inst_in[6:0];
  assign funct3 = inst_in[14:12];
  assign funct6 = inst_in[31:26];
  assign funct7 = inst_in[31:25];
  assign rd     = inst_in[11:7];

  assign imm_i = {{(`XLEN-12){inst_in[31]}}, inst_in[31:20]};
  assign imm_s = {{(`XLEN-12){inst_in[31]}}, inst_in[31:25], inst_in[11:7]};
  assign imm_b = {{(`XLEN-13){inst_in[31]}}, inst_in[31], inst_in[7], inst_in[30:25],
                  inst_in[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){inst_in[31]}}, inst_in[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){inst_in[31]}}, inst_in[31], inst_in[19:12], inst_in[20],
                  inst_in[30:21], 1'b0};
  assign zimm  = {{(`XLEN-5){1'b0}}, inst_in[19:15]};

  // opcode classes
  logic is_load, is_fence, is_op_imm, is_auipc, is_op_imm_w, is_store, is_op;
  logic is_lui, is_op_w, is_branch, is_jalr, is_jal, is_system, is_csr;
  logic is_word, is_reg_form, is_arith, shift_alt, shift_plain;

  assign is_load     = (opcode == 7'h03);
  assign is_fence    = (opcode == 7'h0f);
  assign is_op_imm   = (opcode == 7'h13);
  assign is_auipc    = (opcode == 7'h17);
  assign is_op_imm_w = (opcode == 7'h1b);
  assign is_store    = (opcode == 7'h23);
  assign is_op       = (opcode == 7'h33);
  assign is_lui      = (opcode == 7'h37);
  assign is_op_w     = (opcode == 7'h3b);
  assign is_branch   = (opcode == 7'h63);
  assign is_jalr     = (opcode == 7'h67);
  assign is_jal      = (opcode == 7'h6f);
  assign is_system   = (opcode == 7'h73);
  // ecall, ebreak and mret share funct3 zero
  assign is_csr      = is_system && (funct3[1:0] != 2'b00);

  assign is_word     = is_op_w || is_op_imm_w;
  assign is_reg_form = is_op || is_op_w;
  assign is_arith    = is_reg_form || is_op_imm || is_op_imm_w;
  // R forms mark the alternate op in funct7, shift immediates in funct6
  assign shift_alt   = is_reg_form ? (funct7 == 7'h20) : (funct6 == 6'h10);
  assign shift_plain = is_reg_form ? (funct7 == 7'h00) : (funct6 == 6'h00);

  // one-hot operation flags
  alu_info_t  alu_d;
  bj_info_t   bj_d;
  load_info_t load_d;
  save_info_t save_d;

  always_comb begin
    alu_d  = '0;
    bj_d   = '0;
    load_d = '0;
    save_d = '0;
    // address, upper immediate and link sums
    alu_d[`ALU_ADD] = is_load || is_store || is_lui || is_auipc || is_jal || is_jalr;
    if (is_arith) begin
      case (funct3)
        3'd0: begin
          if (is_reg_form && (funct7 == 7'h20)) alu_d[`ALU_SUB] = 1'b1;
          else if (!is_reg_form || (funct7 == 7'h00)) alu_d[`ALU_ADD] = 1'b1;
        end
        3'd1: alu_d[`ALU_SLL]  = 1'b1;
        3'd2: alu_d[`ALU_SLT]  = !is_word;
        3'd3: alu_d[`ALU_SLTU] = !is_word;
        3'd4: alu_d[`ALU_XOR]  = !is_word;
        3'd5: begin
          alu_d[`ALU_SRA] = shift_alt;
          alu_d[`ALU_SRL] = shift_plain;
        end
        3'd6: alu_d[`ALU_OR]   = !is_word;
        3'd7: alu_d[`ALU_AND]  = !is_word;
        default: ;
      endcase
    end
    // equality compares by xor, ordering by set-less-than
    if (is_branch) begin
      case (funct3)
        3'd0: {bj_d[`BJ_BEQ], alu_d[`ALU_XOR]}   = 2'b11;
        3'd1: {bj_d[`BJ_BNE], alu_d[`ALU_XOR]}   = 2'b11;
        3'd4: {bj_d[`BJ_BLT], alu_d[`ALU_SLT]}   = 2'b11;
        3'd5: {bj_d[`BJ_BGE], alu_d[`ALU_SLT]}   = 2'b11;
        3'd6: {bj_d[`BJ_BLTU], alu_d[`ALU_SLTU]} = 2'b11;
        3'd7: {bj_d[`BJ_BGEU], alu_d[`ALU_SLTU]} = 2'b11;
        default: ;
      endcase
    end
    bj_d[`BJ_JALR] = is_jalr;
    bj_d[`BJ_JAL]  = is_jal;
    if (is_csr) begin
      case (funct3[1:0])
        2'd1: alu_d[`ALU_WRI]  = 1'b1;
        2'd2: alu_d[`ALU_OR]   = 1'b1;
        2'd3: alu_d[`ALU_ANDN] = 1'b1;
        default: ;
      endcase
    end
    if (is_load) begin
      case (funct3)
        3'd0: load_d[`LOAD_LB]  = 1'b1;
        3'd1: load_d[`LOAD_LH]  = 1'b1;
        3'd2: load_d[`LOAD_LW]  = 1'b1;
        3'd3: load_d[`LOAD_LD]  = 1'b1;
        3'd4: load_d[`LOAD_LBU] = 1'b1;
        3'd5: load_d[`LOAD_LHU] = 1'b1;
        3'd6: load_d[`LOAD_LWU] = 1'b1;
        default: ;
      endcase
    end
    if (is_store) begin
      case (funct3)
        3'd0: save_d[`SAVE_SB] = 1'b1;
        3'd1: save_d[`SAVE_SH] = 1'b1;
        3'd2: save_d[`SAVE_SW] = 1'b1;
        3'd3: save_d[`SAVE_SD] = 1'b1;
        default: ;
      endcase
    end
  end

  // register and CSR read addresses, unused sources read x0
  logic rs1_used, rs2_used;

  assign rs1_used = is_load || is_fence || is_op_imm || is_op_imm_w || is_store || is_op
                 || is_op_w || is_branch || is_jalr || (is_csr && !funct3[2]);
  assign rs2_used = is_op || is_op_w || is_store || is_branch;

  assign rs1_addr    = rs1_used ? inst_in[19:15] : '0;
  assign rs2_addr    = rs2_used ? inst_in[24:20] : '0;
  assign csr_rd_addr = inst_in[31:20];

  // operand selection
  xlen_t src1, src2, op1_d, op2_d, jmp_d;

  // word ops see only the low half of each register
  assign src1 = is_word ? {{(`XLEN-32){1'b0}}, r_data1[31:0]} : r_data1;
  assign src2 = is_word ? {{(`XLEN-32){1'b0}}, r_data2[31:0]} : r_data2;

  always_comb begin
    if (is_auipc || is_jal || is_jalr) op1_d = pc_in;
    else if (is_lui) op1_d = '0;
    else if (is_csr) op1_d = csr_data;
    else op1_d = src1;

    if (is_reg_form || is_branch) op2_d = src2;
    else if (is_lui || is_auipc) op2_d = imm_u;
    else if (is_jal || is_jalr) op2_d = xlen_t'(4);
    else if (is_csr) op2_d = funct3[2] ? zimm : src1;
    else if (is_store) op2_d = imm_s;
    else op2_d = imm_i;

    if (is_branch) jmp_d = imm_b;
    else if (is_jal) jmp_d = imm_j;
    else if (is_jalr) jmp_d = imm_i;
    else jmp_d = '0;
  end

  // writeback source and destination
  wb_sel_t wb_d;
  logic    rd_wr;

  assign wb_d[0] = is_fence || is_op_imm || is_auipc || is_op_imm_w || is_op || is_lui
                || is_op_w || is_jalr || is_jal;
  assign wb_d[1] = is_load;
  assign wb_d[2] = is_csr;
  assign rd_wr   = |wb_d;

  // enables that act on memory and on the register files
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_rd_ena <= 1'b0;
      mem_wr_ena <= 1'b0;
      rd_ena     <= 1'b0;
      csr_wr_ena <= 1'b0;
    end else if (accept) begin
      mem_rd_ena <= is_load;
      mem_wr_ena <= is_store;
      rd_ena     <= rd_wr;
      csr_wr_ena <= is_csr;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_out       <= pc_in;
      inst_out     <= inst_in;
      rs1_addr_out <= rs1_addr;
      rs2_addr_out <= rs2_addr;
      ex_op1       <= op1_d;
      ex_op2       <= op2_d;
      jmp_imm      <= jmp_d;
      rs2_data     <= r_data2;
      is_word_opt  <= is_word;
      alu_info     <= alu_d;
      bj_info      <= bj_d;
      load_info    <= load_d;
      save_info    <= save_d;
      reg_wr_ctrl  <= wb_d;
      rd_addr      <= rd_wr ? rd : '0;
      csr_wr_addr  <= inst_in[31:20];
    end
  end

  valid_from_held: assert property (@(posedge clk) disable iff (rst)
    id_ex_valid |-> id_valid);

  // a bundle execute has not taken stays put
  bundle_holds: assert property (@(posedge clk) disable iff (rst)
    (id_valid && !(ex_allowin && !stall)) |=> (id_valid && $stable(inst_out)));

endmodule

`default_nettype wire

//--- logic/decode_issue.sv
// top of the decode slice, ties the decode stage to its register file and CSR file
`default_nettype none

module decode_issue
  import decode_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  // pipeline control
  input  wire            ex_allowin,
  output logic           id_allowin,
  input  wire            if_id_valid,
  output logic           id_ex_valid,
  input  wire            stall,
  // offered instruction
  input  wire xlen_t     pc_in,
  input  wire inst_t     inst_in,
  // decoded bundle
  output xlen_t          pc_out,
  output inst_t          inst_out,
  output reg_addr_t      rs1_addr_out,
  output reg_addr_t      rs2_addr_out,
  output xlen_t          ex_op1,
  output xlen_t          ex_op2,
  output xlen_t          jmp_imm,
  output xlen_t          rs2_data,
  output logic           is_word_opt,
  output alu_info_t      alu_info,
  output bj_info_t       bj_info,
  output load_info_t     load_info,
  output save_info_t     save_info,
  output logic           mem_rd_ena,
  output logic           mem_wr_ena,
  output wb_sel_t        reg_wr_ctrl,
  output logic           rd_ena,
  output reg_addr_t      rd_addr,
  output logic           csr_wr_ena,
  output csr_addr_t      csr_wr_addr,
  // writeback ports
  input  wire            rf_wr_ena,
  input  wire reg_addr_t rf_wr_addr,
  input  wire xlen_t     rf_wr_data,
  input  wire            csr_wr_en,
  input  wire csr_addr_t csr_wr_addr_in,
  input  wire xlen_t     csr_wr_data
);

  // same-cycle operand reads
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  csr_addr_t csr_rd_addr;
  xlen_t     r_data1;
  xlen_t     r_data2;
  xlen_t     csr_data;

  id_stage u_id_stage (
    .clk          (clk),
    .rst          (rst),
    .ex_allowin   (ex_allowin),
    .id_allowin   (id_allowin),
    .if_id_valid  (if_id_valid),
    .id_ex_valid  (id_ex_valid),
    .stall        (stall),
    .pc_in        (pc_in),
    .inst_in      (inst_in),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .csr_rd_addr  (csr_rd_addr),
    .r_data1      (r_data1),
    .r_data2      (r_data2),
    .csr_data     (csr_data),
    .pc_out       (pc_out),
    .inst_out     (inst_out),
    .rs1_addr_out (rs1_addr_out),
    .rs2_addr_out (rs2_addr_out),
    .ex_op1       (ex_op1),
    .ex_op2       (ex_op2),
    .jmp_imm      (jmp_imm),
    .rs2_data     (rs2_data),
    .is_word_opt  (is_word_opt),
    .alu_info     (alu_info),
    .bj_info      (bj_info),
    .load_info    (load_info),
    .save_info    (save_info),
    .mem_rd_ena   (mem_rd_ena),
    .mem_wr_ena   (mem_wr_ena),
    .reg_wr_ctrl  (reg_wr_ctrl),
    .rd_ena       (rd_ena),
    .rd_addr      (rd_addr),
    .csr_wr_ena   (csr_wr_ena),
    .csr_wr_addr  (csr_wr_addr)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rd_addr1 (rs1_addr),
    .rd_addr2 (rs2_addr),
    .rd_data1 (r_data1),
    .rd_data2 (r_data2),
    .wr_ena   (rf_wr_ena),
    .wr_addr  (rf_wr_addr),
    .wr_data  (rf_wr_data)
  );

  csr_file u_csr_file (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (csr_rd_addr),
    .rd_data (csr_data),
    .wr_ena  (csr_wr_en),
    .wr_addr (csr_wr_addr_in),
    .wr_data (csr_wr_data)
  );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// free running clock for the decode testbench, instantiated once by the testbench top
`default_nettype none

module tb_clock #(
  parameter int period = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- test/decode_issue_tb.sv
// directed tests for the decode slice, simulation top that drives decode_issue through its ports
`default_nettype none

`include "decode_params.svh"

module decode_issue_tb
  import decode_pkg::*;
();

  localparam int clk_period   = 20;
  localparam int reset_cycles = 5;
  localparam int accept_limit = 16;
  // rough cycle budget per test, plus slack
  localparam int cycles_reset = 8;
  localparam int cycles_arith = 20;
  localparam int cycles_mem   = 20;
  localparam int cycles_ctrl  = 20;
  localparam int cycles_csr   = 20;
  localparam int cycles_bp    = 24;
  localparam int cycles_slack = 40;
  localparam int watchdog_cycles = reset_cycles + cycles_reset + cycles_arith + cycles_mem
                                 + cycles_ctrl + cycles_csr + cycles_bp + cycles_slack;

  // RV64I major opcodes
  localparam logic [6:0] opc_load   = 7'h03;
  localparam logic [6:0] opc_op_imm = 7'h13;
  localparam logic [6:0] opc_auipc  = 7'h17;
  localparam logic [6:0] opc_store  = 7'h23;
  localparam logic [6:0] opc_op     = 7'h33;
  localparam logic [6:0] opc_lui    = 7'h37;
  localparam logic [6:0] opc_op_w   = 7'h3b;
  localparam logic [6:0] opc_branch = 7'h63;
  localparam logic [6:0] opc_jalr   = 7'h67;
  localparam logic [6:0] opc_jal    = 7'h6f;
  localparam logic [6:0] opc_system = 7'h73;

  logic       clk;
  logic       rst;
  logic       ex_allowin;
  logic       if_id_valid;
  logic       stall;
  xlen_t      pc_in;
  inst_t      inst_in;
  logic       rf_wr_ena;
  reg_addr_t  rf_wr_addr;
  xlen_t      rf_wr_data;
  logic       csr_wr_en;
  csr_addr_t  csr_wr_addr_in;
  xlen_t      csr_wr_data;
  logic       id_allowin;
  logic       id_ex_valid;
  xlen_t      pc_out;
  inst_t      inst_out;
  reg_addr_t  rs1_addr_out;
  reg_addr_t  rs2_addr_out;
  xlen_t      ex_op1;
  xlen_t      ex_op2;
  xlen_t      jmp_imm;
  xlen_t      rs2_data;
  logic       is_word_opt;
  alu_info_t  alu_info;
  bj_info_t   bj_info;
  load_info_t load_info;
  save_info_t save_info;
  logic       mem_rd_ena;
  logic       mem_wr_ena;
  wb_sel_t    reg_wr_ctrl;
  logic       rd_ena;
  reg_addr_t  rd_addr;
  logic       csr_wr_ena;
  csr_addr_t  csr_wr_addr;

  // register contents shared between tests
  xlen_t val_a;
  xlen_t val_b;
  xlen_t mem_base;
  xlen_t mem_data;
  xlen_t scratch_val;
  xlen_t csr_src;

  tb_clock #(.period(clk_period)) u_tb_clock (.clk(clk));

  decode_issue u_decode_issue (
    .clk            (clk),
    .rst            (rst),
    .ex_allowin     (ex_allowin),
    .id_allowin     (id_allowin),
    .if_id_valid    (if_id_valid),
    .id_ex_valid    (id_ex_valid),
    .stall          (stall),
    .pc_in          (pc_in),
    .inst_in        (inst_in),
    .pc_out         (pc_out),
    .inst_out       (inst_out),
    .rs1_addr_out   (rs1_addr_out),
    .rs2_addr_out   (rs2_addr_out),
    .ex_op1         (ex_op1),
    .ex_op2         (ex_op2),
    .jmp_imm        (jmp_imm),
    .rs2_data       (rs2_data),
    .is_word_opt    (is_word_opt),
    .alu_info       (alu_info),
    .bj_info        (bj_info),
    .load_info      (load_info),
    .save_info      (save_info),
    .mem_rd_ena     (mem_rd_ena),
    .mem_wr_ena     (mem_wr_ena),
    .reg_wr_ctrl    (reg_wr_ctrl),
    .rd_ena         (rd_ena),
    .rd_addr        (rd_addr),
    .csr_wr_ena     (csr_wr_ena),
    .csr_wr_addr    (csr_wr_addr),
    .rf_wr_ena      (rf_wr_ena),
    .rf_wr_addr     (rf_wr_addr),
    .rf_wr_data     (rf_wr_data),
    .csr_wr_en      (csr_wr_en),
    .csr_wr_addr_in (csr_wr_addr_in),
    .csr_wr_data    (csr_wr_data)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check(input string test, input string what, input xlen_t expected,
                       input xlen_t actual);
    if (expected !== actual) begin
      abort_run($sformatf("error %s %s expected %h actual %h", test, what, expected, actual));
    end
  endtask

  function automatic xlen_t onehot(input int pos);
    return xlen_t'(1) << pos;
  endfunction

  // RV64I instruction formats
  function automatic inst_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_i(input int imm, input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd, input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_s(input int imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [2:0] f3, input logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic inst_t enc_b(input int imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [2:0] f3, input logic [6:0] op);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
  endfunction

  function automatic inst_t enc_u(input int imm, input reg_addr_t rd, input logic [6:0] op);
    return {imm[19:0], rd, op};
  endfunction

  function automatic inst_t enc_j(input int imm, input reg_addr_t rd, input logic [6:0] op);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
  endfunction

  task automatic write_reg(input reg_addr_t addr, input xlen_t data);
    @(posedge clk);
    rf_wr_ena  <= 1'b1;
    rf_wr_addr <= addr;
    rf_wr_data <= data;
    @(posedge clk);
    rf_wr_ena  <= 1'b0;
  endtask

  task automatic write_csr(input csr_addr_t addr, input xlen_t data);
    @(posedge clk);
    csr_wr_en      <= 1'b1;
    csr_wr_addr_in <= addr;
    csr_wr_data    <= data;
    @(posedge clk);
    csr_wr_en      <= 1'b0;
  endtask

  task automatic drive_offer(input xlen_t pc, input inst_t inst);
    @(posedge clk);
    if_id_valid <= 1'b1;
    pc_in       <= pc;
    inst_in     <= inst;
  endtask

  // waits for id_allowin, lets the edge take the instruction, then samples mid cycle
  task automatic wait_accept();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!id_allowin) begin
      if (waited == accept_limit) begin
        abort_run("decode stage never accepted the offered instruction");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    @(posedge clk);
    if_id_valid <= 1'b0;
    @(negedge clk);
  endtask

  task automatic issue(input xlen_t pc, input inst_t inst);
    drive_offer(pc, inst);
    wait_accept();
  endtask

  task automatic expect_bundle(input string t, input xlen_t op1, input xlen_t op2,
                               input reg_addr_t rd, input wb_sel_t wb);
    check(t, "id_ex_valid", 64'd1, 64'(id_ex_valid));
    check(t, "ex_op1", op1, ex_op1);
    check(t, "ex_op2", op2, ex_op2);
    check(t, "rd_ena", 64'(wb != 3'b000), 64'(rd_ena));
    check(t, "rd_addr", 64'(rd), 64'(rd_addr));
    check(t, "reg_wr_ctrl", 64'(wb), 64'(reg_wr_ctrl));
  endtask

  task automatic arith_case(input string t, input inst_t inst, input xlen_t op1,
                            input xlen_t op2, input int alu_pos, input logic word,
                            input reg_addr_t rd, input reg_addr_t rs1,
                            input reg_addr_t rs2);
    issue(64'h0000_0000_0000_1000, inst);
    expect_bundle(t, op1, op2, rd, 3'b001);
    check(t, "alu_info", onehot(alu_pos), 64'(alu_info));
    check(t, "is_word_opt", 64'(word), 64'(is_word_opt));
    check(t, "rs1_addr_out", 64'(rs1), 64'(rs1_addr_out));
    check(t, "rs2_addr_out", 64'(rs2), 64'(rs2_addr_out));
  endtask

  task automatic mem_case(input string t, input inst_t inst, input int off,
                          input reg_addr_t rd, input logic is_ld, input int pos);
    issue(64'h0000_0000_0000_2000, inst);
    expect_bundle(t, mem_base, xlen_t'(off), rd, is_ld ? 3'b010 : 3'b000);
    check(t, "mem_rd_ena", 64'(is_ld), 64'(mem_rd_ena));
    check(t, "mem_wr_ena", 64'(!is_ld), 64'(mem_wr_ena));
    check(t, "load_info", is_ld ? onehot(pos) : 64'd0, 64'(load_info));
    check(t, "save_info", is_ld ? 64'd0 : onehot(pos), 64'(save_info));
    if (!is_ld) begin
      check(t, "rs2_data", mem_data, rs2_data);
    end
  endtask

  task automatic test_reset();
    @(negedge clk);
    check("test_reset", "id_ex_valid", 64'd0, 64'(id_ex_valid));
    check("test_reset", "id_allowin", 64'd1, 64'(id_allowin));
    repeat (3) begin
      @(negedge clk);
      check("test_reset", "idle id_ex_valid", 64'd0, 64'(id_ex_valid));
    end
  endtask

  task automatic test_arith();
    val_a = {$urandom, $urandom};
    val_b = {$urandom, $urandom};
    write_reg(5'd5, val_a);
    write_reg(5'd6, val_b);
    arith_case("test_arith add", enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd7, opc_op),
               val_a, val_b, `ALU_ADD, 1'b0, 5'd7, 5'd5, 5'd6);
    arith_case("test_arith sub", enc_r(7'h20, 5'd6, 5'd5, 3'd0, 5'd8, opc_op),
               val_a, val_b, `ALU_SUB, 1'b0, 5'd8, 5'd5, 5'd6);
    // immediate form has no rs2, its read address is x0
    arith_case("test_arith addi", enc_i(-100, 5'd5, 3'd0, 5'd9, opc_op_imm),
               val_a, xlen_t'(-100), `ALU_ADD, 1'b0, 5'd9, 5'd5, 5'd0);
    // word form sees only the low halves
    arith_case("test_arith subw", enc_r(7'h20, 5'd6, 5'd5, 3'd0, 5'd10, opc_op_w),
               {32'h0, val_a[31:0]}, {32'h0, val_b[31:0]}, `ALU_SUB, 1'b1, 5'd10,
               5'd5, 5'd6);
  endtask

  task automatic test_mem();
    mem_base = {$urandom, $urandom};
    mem_data = {$urandom, $urandom};
    write_reg(5'd11, mem_base);
    write_reg(5'd12, mem_data);
    mem_case("test_mem ld", enc_i(-8, 5'd11, 3'd3, 5'd13, opc_load),
             -8, 5'd13, 1'b1, `LOAD_LD);
    mem_case("test_mem lbu", enc_i(-1, 5'd11, 3'd4, 5'd14, opc_load),
             -1, 5'd14, 1'b1, `LOAD_LBU);
    mem_case("test_mem sd", enc_s(-24, 5'd12, 5'd11, 3'd3, opc_store),
             -24, 5'd0, 1'b0, `SAVE_SD);
    mem_case("test_mem sb", enc_s(-3, 5'd12, 5'd11, 3'd0, opc_store),
             -3, 5'd0, 1'b0, `SAVE_SB);
  endtask

  task automatic test_control();
    xlen_t pc;
    pc = 64'h0000_0000_8000_1000;
    issue(pc, enc_b(-16, 5'd6, 5'd5, 3'd0, opc_branch));
    expect_bundle("test_control beq", val_a, val_b, 5'd0, 3'b000);
    check("test_control beq", "bj_info", onehot(`BJ_BEQ), 64'(bj_info));
    check("test_control beq", "jmp_imm", xlen_t'(-16), jmp_imm);
    issue(pc, enc_j(-2048, 5'd1, opc_jal));
    expect_bundle("test_control jal", pc, 64'd4, 5'd1, 3'b001);
    check("test_control jal", "bj_info", onehot(`BJ_JAL), 64'(bj_info));
    check("test_control jal", "jmp_imm", xlen_t'(-2048), jmp_imm);
    issue(pc, enc_i(-4, 5'd5, 3'd0, 5'd1, opc_jalr));
    expect_bundle("test_control jalr", pc, 64'd4, 5'd1, 3'b001);
    check("test_control jalr", "bj_info", onehot(`BJ_JALR), 64'(bj_info));
    check("test_control jalr", "jmp_imm", xlen_t'(-4), jmp_imm);
    issue(pc, enc_u('hfffff, 5'd15, opc_lui));
    expect_bundle("test_control lui", 64'd0, 64'hffff_ffff_ffff_f000, 5'd15, 3'b001);
    issue(pc, enc_u('h12345, 5'd16, opc_auipc));
    expect_bundle("test_control auipc", pc, 64'h0000_0000_1234_5000, 5'd16, 3'b001);
  endtask

  task automatic test_csr();
    scratch_val = {$urandom, $urandom};
    csr_src     = {$urandom, $urandom};
    write_csr(`CSR_MSCRATCH, scratch_val);
    write_reg(5'd17, csr_src);
    issue(64'h3000, enc_i('h340, 5'd17, 3'd2, 5'd18, opc_system));
    expect_bundle("test_csr csrrs", scratch_val, csr_src, 5'd18, 3'b100);
    check("test_csr csrrs", "alu_info", onehot(`ALU_OR), 64'(alu_info));
    check("test_csr csrrs", "csr_wr_ena", 64'd1, 64'(csr_wr_ena));
    check("test_csr csrrs", "csr_wr_addr", 64'h340, 64'(csr_wr_addr));
    // rs1 field carries zimm
    issue(64'h3004, enc_i('h340, 5'd21, 3'd5, 5'd19, opc_system));
    expect_bundle("test_csr csrrwi", scratch_val, 64'd21, 5'd19, 3'b100);
    check("test_csr csrrwi", "alu_info", onehot(`ALU_WRI), 64'(alu_info));
    check("test_csr csrrwi", "csr_wr_ena", 64'd1, 64'(csr_wr_ena));
    check("test_csr csrrwi", "csr_wr_addr", 64'h340, 64'(csr_wr_addr));
    issue(64'h3008, enc_i('h7c0, 5'd17, 3'd2, 5'd20, opc_system));
    expect_bundle("test_csr unknown", 64'd0, csr_src, 5'd20, 3'b100);
  endtask

  task automatic test_backpressure();
    inst_t first;
    inst_t second;
    first  = enc_i(5, 5'd5, 3'd0, 5'd21, opc_op_imm);
    second = enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd22, opc_op);
    @(posedge clk);
    ex_allowin <= 1'b0;
    issue(64'h4000, first);
    check("test_backpressure", "id_ex_valid", 64'd1, 64'(id_ex_valid));
    check("test_backpressure", "id_allowin", 64'd0, 64'(id_allowin));
    drive_offer(64'h4004, second);
    repeat (3) begin
      @(negedge clk);
      check("test_backpressure", "held id_allowin", 64'd0, 64'(id_allowin));
      check("test_backpressure", "held inst_out", 64'(first), 64'(inst_out));
      check("test_backpressure", "held pc_out", 64'h4000, pc_out);
      check("test_backpressure", "held ex_op2", 64'd5, ex_op2);
    end
    @(posedge clk);
    stall <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      check("test_backpressure", "stalled id_ex_valid", 64'd0, 64'(id_ex_valid));
      check("test_backpressure", "stalled id_allowin", 64'd0, 64'(id_allowin));
      check("test_backpressure", "stalled inst_out", 64'(first), 64'(inst_out));
    end
    @(posedge clk);
    stall      <= 1'b0;
    ex_allowin <= 1'b1;
    wait_accept();
    check("test_backpressure", "released inst_out", 64'(second), 64'(inst_out));
    check("test_backpressure", "released pc_out", 64'h4004, pc_out);
    expect_bundle("test_backpressure", val_a, val_b, 5'd22, 3'b001);
    check("test_backpressure", "alu_info", onehot(`ALU_ADD), 64'(alu_info));
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    rst            = 1'b1;
    ex_allowin     = 1'b1;
    if_id_valid    = 1'b0;
    stall          = 1'b0;
    pc_in          = '0;
    inst_in        = '0;
    rf_wr_ena      = 1'b0;
    rf_wr_addr     = '0;
    rf_wr_data     = '0;
    csr_wr_en      = 1'b0;
    csr_wr_addr_in = '0;
    csr_wr_data    = '0;
    void'($urandom(32'h4328a25e));
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_arith();
    test_mem();
    test_control();
    test_csr();
    test_backpressure();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- decode_issue.f
+incdir+logic
logic/decode_pkg.sv
logic/reg_file.sv
logic/csr_file.sv
logic/id_stage.sv
logic/decode_issue.sv
test/tb_clock.sv
test/decode_issue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the decode testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module decode_issue_tb \
  -f decode_issue.f \
  -o decode_issue_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/decode_issue_sim 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qxF "all tests passed" <<< "$sim_output"; then
  exit 0
else
  exit 1
fi
